// ==== files.f ====
source/noc_wide_pkg.sv
source/noc_narrow_pkg.sv
source/wide_to_narrow.sv
source/noc_data_to_ctrl.sv
source/ctrl_noc_merge.sv
source/ctrl_bridge_top.sv
verification/ctrl_bridge_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the bridge testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 -f files.f \
    --top-module ctrl_bridge_tb -o ctrl_bridge_sim \
    || { echo "build failed"; exit 1; }
out="$(./obj_dir/ctrl_bridge_sim)"
echo "$out"
echo "$out" | grep -q "^Testbench passed$" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== source/ctrl_bridge_top.sv ====
module ctrl_bridge_top (
     input  logic                           clk
    ,input  logic                           rst

    ,input  logic                           wide_val_0
    ,input  noc_wide_pkg::wide_flit_t       wide_flit_0
    ,output logic                           wide_rdy_0

    ,input  logic                           wide_val_1
    ,input  noc_wide_pkg::wide_flit_t       wide_flit_1
    ,output logic                           wide_rdy_1

    ,output logic                           out_val
    ,output noc_narrow_pkg::narrow_flit_u   out_flit
    ,input  logic                           out_rdy
);

    import noc_narrow_pkg::*;

    narrow_stream_t conv_0;
    narrow_stream_t conv_1;
    logic           rdy_0;
    logic           rdy_1;

    noc_data_to_ctrl i_conv_0 (
         .clk           (clk)
        ,.rst           (rst)
        ,.wide_val      (wide_val_0)
        ,.wide_flit     (wide_flit_0)
        ,.wide_rdy      (wide_rdy_0)
        ,.narrow        (conv_0)
        ,.narrow_rdy    (rdy_0)
    );

    noc_data_to_ctrl i_conv_1 (
         .clk           (clk)
        ,.rst           (rst)
        ,.wide_val      (wide_val_1)
        ,.wide_flit     (wide_flit_1)
        ,.wide_rdy      (wide_rdy_1)
        ,.narrow        (conv_1)
        ,.narrow_rdy    (rdy_1)
    );

    ctrl_noc_merge i_merge (
         .clk       (clk)
        ,.rst       (rst)
        ,.in0       (conv_0)
        ,.rdy0      (rdy_0)
        ,.in1       (conv_1)
        ,.rdy1      (rdy_1)
        ,.out_val   (out_val)
        ,.out_flit  (out_flit)
        ,.out_rdy   (out_rdy)
    );

endmodule

// ==== source/ctrl_noc_merge.sv ====
module ctrl_noc_merge (
     input  logic                           clk
    ,input  logic                           rst

    ,input  noc_narrow_pkg::narrow_stream_t in0
    ,output logic                           rdy0
    ,input  noc_narrow_pkg::narrow_stream_t in1
    ,output logic                           rdy1

    ,output logic                           out_val
    ,output noc_narrow_pkg::narrow_flit_u   out_flit
    ,input  logic                           out_rdy
);

    import noc_wide_pkg::*;
    import noc_narrow_pkg::*;

    logic           locked;
    logic           gnt;
    logic           prio;
    logic           prio_val;
    logic           sel;
    narrow_stream_t sel_in;
    logic           fire;

    logic           in_pkt; // route header of the current packet already sent
    msg_len_t       flits_left;

    assign prio_val = prio ? in1.val : in0.val;
    assign sel = locked ? gnt : (prio_val ? prio : ~prio);
    assign sel_in = sel ? in1 : in0;

    assign out_val = sel_in.val;
    assign out_flit = sel_in.flit;
    assign fire = out_val & out_rdy;

    assign rdy0 = out_rdy & sel_in.val & ~sel;
    assign rdy1 = out_rdy & sel_in.val & sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
            gnt <= 1'b0;
            prio <= 1'b0;
        end
        else if (fire && sel_in.last) begin
            locked <= 1'b0;
            prio <= ~sel; // other port goes first next time
        end
        else if (out_val) begin
            // hold the choice once offered, even if stalled
            locked <= 1'b1;
            gnt <= sel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_pkt <= 1'b0;
            flits_left <= '0;
        end
        else if (fire) begin
            in_pkt <= ~sel_in.last;
            if (!in_pkt) begin
                flits_left <= sel_in.flit.route.msg_len;
            end
            else begin
                flits_left <= flits_left - 1'b1;
            end
        end
    end

    a_one_rdy: assert property (@(posedge clk) disable iff (rst)
        !(rdy0 && rdy1));

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_val && !out_rdy |=> out_val && $stable(out_flit));

    // last marking from the converter agrees with its rewritten length
    a_len_match: assert property (@(posedge clk) disable iff (rst)
        fire |-> sel_in.last == (in_pkt && flits_left == msg_len_t'(1)));

endmodule

// ==== source/noc_data_to_ctrl.sv ====
module noc_data_to_ctrl (
     input  logic                           clk
    ,input  logic                           rst

    ,input  logic                           wide_val
    ,input  noc_wide_pkg::wide_flit_t       wide_flit
    ,output logic                           wide_rdy

    ,output noc_narrow_pkg::narrow_stream_t narrow
    ,input  logic                           narrow_rdy
);

    import noc_wide_pkg::*;
    import noc_narrow_pkg::*;

    typedef enum logic [1:0] {
        IDLE        = 2'd0,
        MISC_HDR    = 2'd1,
        PASS_DATA   = 2'd2,
        DRAIN       = 2'd3
    } state_e;

    typedef enum logic [1:0] {
        SEL_ROUTE,
        SEL_MISC,
        SEL_DATA
    } flit_sel_e;

    state_e         state;
    state_e         state_next;
    flit_sel_e      mux_sel;

    wide_hdr_t      live_hdr;
    wide_hdr_t      hdr_reg;
    msg_len_t       count;
    logic           store_hdr;
    logic           decr_count;

    narrow_flit_u   route_flit;
    narrow_flit_u   misc_flit;
    logic           narrow_val;

    logic           wtn_in_val;
    logic           wtn_in_last;
    logic           wtn_in_rdy;
    narrow_stream_t wtn_out;
    logic           wtn_out_rdy;

    assign live_hdr = wide_hdr_t'(wide_flit);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            count <= '0;
        end
        else begin
            state <= state_next;
            if (store_hdr) begin
                count <= live_hdr.msg_len;
            end
            else if (decr_count) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_hdr) begin
            hdr_reg <= live_hdr;
        end
    end

    always_comb begin
        state_next = state;
        mux_sel = SEL_ROUTE;
        narrow_val = 1'b0;
        wide_rdy = 1'b0;
        wtn_in_val = 1'b0;
        wtn_in_last = 1'b0;
        wtn_out_rdy = 1'b0;
        store_hdr = 1'b0;
        decr_count = 1'b0;
        case (state)
            IDLE: begin
                // route flit goes out in the same cycle as the wide header
                narrow_val = wide_val;
                wide_rdy = narrow_rdy;
                if (wide_val && narrow_rdy) begin
                    store_hdr = 1'b1;
                    state_next = MISC_HDR;
                end
            end
            MISC_HDR: begin
                mux_sel = SEL_MISC;
                narrow_val = 1'b1;
                if (narrow_rdy) begin
                    state_next = (count == '0) ? IDLE : PASS_DATA;
                end
            end
            PASS_DATA: begin
                mux_sel = SEL_DATA;
                narrow_val = wtn_out.val;
                wtn_out_rdy = narrow_rdy;
                wtn_in_val = wide_val;
                wtn_in_last = (count == msg_len_t'(1));
                wide_rdy = wtn_in_rdy;
                if (wide_val && wtn_in_rdy) begin
                    decr_count = 1'b1;
                    if (wtn_in_last) begin
                        state_next = DRAIN;
                    end
                end
            end
            default: begin // DRAIN
                mux_sel = SEL_DATA;
                narrow_val = wtn_out.val;
                wtn_out_rdy = narrow_rdy;
                if (wtn_out.val && narrow_rdy && wtn_out.last) begin
                    state_next = IDLE;
                end
            end
        endcase
    end

    wide_to_narrow i_wide_to_narrow (
         .clk       (clk)
        ,.rst       (rst)
        ,.in_val    (wtn_in_val)
        ,.in_flit   (wide_flit)
        ,.in_last   (wtn_in_last)
        ,.in_rdy    (wtn_in_rdy)
        ,.out       (wtn_out)
        ,.out_rdy   (wtn_out_rdy)
    );

    always_comb begin
        route_flit.raw = wide_flit[WIDE_W-1 -: NARROW_W];
        // extra one accounts for the misc header flit
        route_flit.route.msg_len = msg_len_t'((live_hdr.msg_len << FLIT_SHIFT) + 1'b1);
    end

    always_comb begin
        misc_flit.raw = '0;
        misc_flit.misc.src_chip_id = hdr_reg.src_chip_id;
        misc_flit.misc.src_x = hdr_reg.src_x;
        misc_flit.misc.src_y = hdr_reg.src_y;
        misc_flit.misc.src_fbits = hdr_reg.src_fbits;
        misc_flit.misc.metadata_flits = hdr_reg.metadata_flits << FLIT_SHIFT;
    end

    always_comb begin
        narrow.val = narrow_val;
        case (mux_sel)
            SEL_ROUTE: begin
                narrow.last = 1'b0;
                narrow.flit = route_flit;
            end
            SEL_MISC: begin
                narrow.last = (count == '0); // header-only packet ends here
                narrow.flit = misc_flit;
            end
            default: begin
                narrow.last = wtn_out.last;
                narrow.flit = wtn_out.flit;
            end
        endcase
    end

    // data pass only happens with wide flits still owed
    a_count_live: assert property (@(posedge clk) disable iff (rst)
        state == PASS_DATA |-> count != '0);

endmodule

// ==== source/noc_narrow_pkg.sv ====
package noc_narrow_pkg;

    localparam int NARROW_W = 64;

    // narrow flits carried by one wide flit
    localparam int FLIT_RATIO = noc_wide_pkg::WIDE_W / NARROW_W;
    localparam int FLIT_SHIFT = $clog2(FLIT_RATIO);

    localparam int MISC_PAD_W = NARROW_W - noc_wide_pkg::ENDPOINT_W - noc_wide_pkg::META_W;

    // first flit of a narrow packet, same layout as the top of the wide header
    typedef struct packed {
        logic [noc_wide_pkg::CHIP_ID_W-1:0]     dst_chip_id;
        logic [noc_wide_pkg::XY_W-1:0]          dst_x;
        logic [noc_wide_pkg::XY_W-1:0]          dst_y;
        logic [noc_wide_pkg::FBITS_W-1:0]       dst_fbits;
        noc_wide_pkg::msg_len_t                 msg_len; // narrow flits after this one
        logic [noc_wide_pkg::MSG_TYPE_W-1:0]    msg_type;
    } narrow_route_hdr_t;

    // second flit, source side of the packet
    typedef struct packed {
        logic [noc_wide_pkg::CHIP_ID_W-1:0]     src_chip_id;
        logic [noc_wide_pkg::XY_W-1:0]          src_x;
        logic [noc_wide_pkg::XY_W-1:0]          src_y;
        logic [noc_wide_pkg::FBITS_W-1:0]       src_fbits;
        logic [noc_wide_pkg::META_W-1:0]        metadata_flits;
        logic [MISC_PAD_W-1:0]                  padding;
    } narrow_misc_hdr_t;

    typedef union packed {
        logic [NARROW_W-1:0]    raw;
        narrow_route_hdr_t      route;
        narrow_misc_hdr_t       misc;
    } narrow_flit_u;

    typedef struct packed {
        logic           val;
        logic           last;
        narrow_flit_u   flit;
    } narrow_stream_t;

endpackage

// ==== source/noc_wide_pkg.sv ====
package noc_wide_pkg;

    localparam int WIDE_W = 256;
    localparam int MSG_LEN_W = 8;

    // field widths shared by the wide and narrow headers
    localparam int CHIP_ID_W = 16;
    localparam int XY_W = 12;
    localparam int FBITS_W = 8;
    localparam int MSG_TYPE_W = 8;
    localparam int META_W = 8;

    localparam int ENDPOINT_W = CHIP_ID_W + 2 * XY_W + FBITS_W;
    localparam int HDR_PAD_W = WIDE_W - 2 * ENDPOINT_W - MSG_LEN_W - MSG_TYPE_W - META_W;

    typedef logic [WIDE_W-1:0] wide_flit_t;

    typedef logic [MSG_LEN_W-1:0] msg_len_t; // counts data flits only

    // the top 64 bits line up with the narrow routing header
    typedef struct packed {
        logic [CHIP_ID_W-1:0]   dst_chip_id;
        logic [XY_W-1:0]        dst_x;
        logic [XY_W-1:0]        dst_y;
        logic [FBITS_W-1:0]     dst_fbits;
        msg_len_t               msg_len;
        logic [MSG_TYPE_W-1:0]  msg_type;
        logic [CHIP_ID_W-1:0]   src_chip_id;
        logic [XY_W-1:0]        src_x;
        logic [XY_W-1:0]        src_y;
        logic [FBITS_W-1:0]     src_fbits;
        logic [META_W-1:0]      metadata_flits;
        logic [HDR_PAD_W-1:0]   padding;
    } wide_hdr_t;

endpackage

// ==== source/wide_to_narrow.sv ====
module wide_to_narrow (
     input  logic                           clk
    ,input  logic                           rst

    ,input  logic                           in_val
    ,input  noc_wide_pkg::wide_flit_t       in_flit
    ,input  logic                           in_last
    ,output logic                           in_rdy

    ,output noc_narrow_pkg::narrow_stream_t out
    ,input  logic                           out_rdy
);

    import noc_wide_pkg::*;
    import noc_narrow_pkg::*;

    wide_flit_t             buf_flit;
    logic                   buf_full;
    logic                   buf_last;
    logic [FLIT_SHIFT-1:0]  slice_idx;

    logic                   last_slice;
    logic                   in_fire;
    logic                   out_fire;

    assign last_slice = (slice_idx == FLIT_SHIFT'(FLIT_RATIO - 1));
    assign out_fire = buf_full & out_rdy;
    assign in_fire = in_val & in_rdy;

    // refill in the same cycle the final slice leaves
    assign in_rdy = ~buf_full | (out_fire & last_slice);

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_full <= 1'b0;
            buf_last <= 1'b0;
            slice_idx <= '0;
        end
        else begin
            if (in_fire) begin
                buf_full <= 1'b1;
                buf_last <= in_last;
                slice_idx <= '0;
            end
            else if (out_fire) begin
                if (last_slice) begin
                    buf_full <= 1'b0;
                end
                slice_idx <= slice_idx + 1'b1;
            end
        end
    end

    // shift the next slice up to the top after each narrow transfer
    always_ff @(posedge clk) begin
        if (in_fire) begin
            buf_flit <= in_flit;
        end
        else if (out_fire) begin
            buf_flit <= buf_flit << NARROW_W;
        end
    end

    always_comb begin
        out.val = buf_full;
        out.last = buf_last & last_slice; // last only on the final slice of the packet
        out.flit.raw = buf_flit[WIDE_W-1 -: NARROW_W];
    end

    // the upstream source must hold a stalled flit
    a_in_hold: assert property (@(posedge clk) disable iff (rst)
        in_val && !in_rdy |=> in_val && $stable(in_flit));

endmodule

// ==== verification/ctrl_bridge_tb.sv ====
module ctrl_bridge_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import noc_wide_pkg::*;
    import noc_narrow_pkg::*;

    localparam int CYCLES_PER_RECORD = 200;
    localparam int WATCHDOG_MARGIN = 100;

    logic               clk;
    logic               rst;
    logic [1:0]         wide_val;
    wide_flit_t         wide_flit [2];
    logic [1:0]         wide_rdy;
    logic               out_val;
    narrow_flit_u       out_flit;
    logic               out_rdy;

    wide_flit_t         wide_q [2][$];
    narrow_flit_u       exp_q [2][$];
    int                 exp_len [2][$]; // narrow flits per packet, headers included
    logic [XY_W-1:0]    port_src_x [2];
    int                 n_records;
    logic [1:0]         offer_val; // wide_val in the cycle a flit was first offered
    int                 last_port;

    ctrl_bridge_top i_ctrl_bridge_top (
         .clk           (clk)
        ,.rst           (rst)
        ,.wide_val_0    (wide_val[0])
        ,.wide_flit_0   (wide_flit[0])
        ,.wide_rdy_0    (wide_rdy[0])
        ,.wide_val_1    (wide_val[1])
        ,.wide_flit_1   (wide_flit[1])
        ,.wide_rdy_1    (wide_rdy[1])
        ,.out_val       (out_val)
        ,.out_flit      (out_flit)
        ,.out_rdy       (out_rdy)
    );

    always #2 clk = ~clk;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_route_hdr(input narrow_route_hdr_t got, input narrow_route_hdr_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH time=%0t signal=out_flit.route got=%h exp=%h",
                $time, got, exp));
        end
    endtask

    task automatic check_misc_hdr(input narrow_misc_hdr_t got, input narrow_misc_hdr_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH time=%0t signal=out_flit.misc got=%h exp=%h",
                $time, got, exp));
        end
    endtask

    task automatic check_data(input narrow_flit_u got, input narrow_flit_u exp);
        if (got.raw !== exp.raw) begin
            stop_on_error($sformatf("MISMATCH time=%0t signal=out_flit.raw got=%h exp=%h",
                $time, got.raw, exp.raw));
        end
    endtask

    // P opens a packet, W is a wide flit, R M D are the narrow flits it should become
    task automatic load_testdata();
        int                 fd;
        int                 port;
        string              line;
        byte                tag;
        logic [WIDE_W-1:0]  word;
        narrow_flit_u       nf;
        port = 0;
        fd = $fopen("verification/ctrl_bridge_testdata.txt", "r");
        if (fd == 0) begin
            stop_on_error("cannot open verification/ctrl_bridge_testdata.txt");
        end
        else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 2 && line[0] != "#") begin
                    void'($sscanf(line, "%c %h", tag, word));
                    nf.raw = word[NARROW_W-1:0];
                    case (tag)
                        "P": begin
                            port = word[0] ? 1 : 0;
                            n_records++;
                            exp_len[port].push_back(0);
                        end
                        "W": wide_q[port].push_back(word);
                        "R", "M", "D": begin
                            exp_q[port].push_back(nf);
                            exp_len[port][exp_len[port].size() - 1] += 1;
                            if (tag == "M") begin
                                port_src_x[port] = nf.misc.src_x; // tells the ports apart
                            end
                        end
                        default: stop_on_error("unknown line type in the testdata file");
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_port(input int port);
        wide_flit_t f;
        int         gap;
        @(negedge clk);
        while (wide_q[port].size() > 0) begin
            f = wide_q[port].pop_front();
            gap = $urandom % 3;
            repeat (gap) begin
                wide_val[port] = 1'b0;
                @(negedge clk);
            end
            wide_val[port] = 1'b1;
            wide_flit[port] = f;
            #1;
            while (!wide_rdy[port]) begin // hold until taken
                @(negedge clk);
                #1;
            end
            @(negedge clk);
        end
        wide_val[port] = 1'b0;
    endtask

    // sampled a little before the rising edge, when the handshake is settled
    task automatic take_out_flit(output narrow_flit_u f);
        logic got;
        logic seen;
        got = 1'b0;
        seen = 1'b0;
        while (!got) begin
            @(negedge clk);
            #1;
            if (out_val && !seen) begin
                seen = 1'b1;
                offer_val = wide_val; // who was waiting when the merger chose
            end
            got = out_val && out_rdy;
        end
        f = out_flit;
    endtask

    task automatic check_packet();
        narrow_flit_u   route_f;
        narrow_flit_u   misc_f;
        narrow_flit_u   data_f;
        narrow_flit_u   exp_f;
        logic [1:0]     pending;
        int             port;
        int             len;
        port = 0;
        take_out_flit(route_f);
        pending = offer_val;
        take_out_flit(misc_f);
        if (misc_f.misc.src_x == port_src_x[0]) begin
            port = 0;
        end
        else if (misc_f.misc.src_x == port_src_x[1]) begin
            port = 1;
        end
        else begin
            stop_on_error($sformatf("packet with unknown source src_x=%h", misc_f.misc.src_x));
        end
        // a waiting port goes ahead of the port that sent the previous packet
        if (port == last_port && pending[1 - port]) begin
            stop_on_error($sformatf("port %0d was granted again while port %0d was waiting",
                port, 1 - port));
        end
        last_port = port;
        if (exp_len[port].size() == 0) begin
            stop_on_error($sformatf("extra packet from port %0d", port));
        end
        len = exp_len[port].pop_front();
        exp_f = exp_q[port].pop_front();
        check_route_hdr(route_f.route, exp_f.route);
        exp_f = exp_q[port].pop_front();
        check_misc_hdr(misc_f.misc, exp_f.misc);
        for (int i = 2; i < len; i++) begin
            take_out_flit(data_f);
            exp_f = exp_q[port].pop_front();
            check_data(data_f, exp_f);
        end
    endtask

    // downstream stalls about one cycle in four
    initial begin
        out_rdy = 1'b0;
        forever begin
            @(negedge clk);
            out_rdy = ($urandom % 4) != 0;
        end
    end

    initial begin
        wait (rst === 1'b0);
        repeat (CYCLES_PER_RECORD * n_records + WATCHDOG_MARGIN) @(posedge clk);
        $display("timeout: packets still missing after %0d cycles",
            CYCLES_PER_RECORD * n_records + WATCHDOG_MARGIN);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        wide_val = '0;
        wide_flit[0] = '0;
        wide_flit[1] = '0;
        n_records = 0;
        offer_val = '0;
        last_port = 1; // priority starts on port 0
        void'($urandom(32'hd50b));
        load_testdata();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fork
            drive_port(0);
            drive_port(1);
            repeat (n_records) check_packet();
        join
        repeat (20) begin // nothing may follow the last packet
            @(negedge clk);
            #1;
            if (out_val) begin
                stop_on_error("output valid after the last expected packet");
            end
        end
        if (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            stop_on_error("expected narrow flits were never seen");
        end
        else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== verification/ctrl_bridge_testdata.txt ====
# P <port> opens a packet, W <wide flit hex> in send order
# R, M, D <narrow flit hex> expected route header, misc header and data slices
P 0
W 000100300400001100020a100506020000000000000000000000000000000000
R 0001003004000111
M 00020a1005060800
P 1
W 00aa1234567f01220bbb0b200c3c05ffffffffffffffffffffffffffffffffff
W 1111111111111111222222222222222233333333333333334444444444444444
R 00aa1234567f0522
M 0bbb0b200c3c1400
D 1111111111111111
D 2222222222222222
D 3333333333333333
D 4444444444444444
P 0
W 010001002001023300020a100700030000000000000000000000000000000000
W 0123456789abcdeffedcba9876543210a5a5a5a5a5a5a5a55a5a5a5a5a5a5a5a
W c0c0c0c0c0c0c0c0c1c1c1c1c1c1c1c1c2c2c2c2c2c2c2c2c3c3c3c3c3c3c3c3
R 0100010020010933
M 00020a1007000c00
D 0123456789abcdef
D fedcba9876543210
D a5a5a5a5a5a5a5a5
D 5a5a5a5a5a5a5a5a
D c0c0c0c0c0c0c0c0
D c1c1c1c1c1c1c1c1
D c2c2c2c2c2c2c2c2
D c3c3c3c3c3c3c3c3
P 1
W 00030010020300440bbb0b200d3d000000000000000000000000000000000000
R 0003001002030144
M 0bbb0b200d3d0000
